// File: source/fetch_settings.svh
// sizes shared by the fetch stage 2 RTL and testbench.
// include wherever a width or depth is needed.
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// program counter width.
`define SIZE_PC 32

// raw instruction word width.
`define SIZE_INSTRUCTION 32

// slots per fetched bundle.
`define FETCH_BANDWIDTH 4

// control-transfer queue entries, tag width must cover them.
`define CTIQ_DEPTH 16
`define SIZE_CTI_LOG 4

`endif

// File: source/fetchIsaPkg.sv
// instruction set view used by pre-decode.
// opcodes, control types and the two readings of an instruction word.
package fetchIsaPkg;

  typedef logic [5:0] opcodeT;

  // control-transfer classes, encoding matches the predictor update bus.
  typedef enum logic [1:0] {
    ctrlReturn     = 2'b00,
    ctrlCall       = 2'b01,
    ctrlJump       = 2'b10,
    ctrlCondBranch = 2'b11
  } ctrlTypeE;

  localparam opcodeT opJ   = 6'h02;
  localparam opcodeT opJal = 6'h03;
  localparam opcodeT opBeq = 6'h04;
  localparam opcodeT opBne = 6'h05;
  localparam opcodeT opJr  = 6'h08; // return through link register.

  // conditional branch format.
  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] offset; // signed word offset from pc + 4.
  } branchFmtT;

  // jump and call format.
  typedef struct packed {
    opcodeT      opcode;
    logic [25:0] index;
  } jumpFmtT;

  // one 32-bit word, decoded either way.
  typedef union packed {
    branchFmtT br;
    jumpFmtT   jmp;
  } instrU;

endpackage

// File: source/fetchPipePkg.sv
// pipeline word types carried between fetch stage 2 and its queue.
package fetchPipePkg;

  `include "fetch_settings.svh"

  // one program counter.
  typedef logic [`SIZE_PC-1:0] pcT;

  // control queue entry index.
  typedef logic [`SIZE_CTI_LOG-1:0] ctiqTagT;

  // one bit per bundle slot, bit i is slot i.
  typedef logic [`FETCH_BANDWIDTH-1:0] slotMaskT;

endpackage

// File: source/preDecode.sv
// single slot pre-decoder.
// classifies one instruction and forms its control-transfer target.
`timescale 1ns/1ps
`include "fetch_settings.svh"

module preDecode import fetchIsaPkg::*, fetchPipePkg::*; (
  input  pcT       pc_i,
  input  instrU    instruction_i,
  input  pcT       btbTarget_i,
  output logic     isCtrl_o,
  output ctrlTypeE ctrlType_o,
  output pcT       target_o
);

  pcT nextPc;
  pcT branchTarget;
  pcT jumpTarget;

  assign nextPc = pc_i + pcT'(4);

  // word offset, sign extended and scaled by four.
  assign branchTarget = nextPc + {{(`SIZE_PC-18){instruction_i.br.offset[15]}},
                                  instruction_i.br.offset, 2'b00};

  assign jumpTarget = {pc_i[`SIZE_PC-1 -: 4], instruction_i.jmp.index, 2'b00}; // region jump.

  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = ctrlJump;
    target_o   = nextPc;
    case (instruction_i.br.opcode)
      opJr: begin
        ctrlType_o = ctrlReturn;
        target_o   = btbTarget_i; // the stage swaps in the ras address on a miss.
      end
      opJal: begin
        ctrlType_o = ctrlCall;
        target_o   = jumpTarget;
      end
      opJ: begin
        target_o = jumpTarget;
      end
      opBeq, opBne: begin
        ctrlType_o = ctrlCondBranch;
        target_o   = branchTarget;
      end
      default: begin
        isCtrl_o = 1'b0; // sequential, target stays pc + 4.
      end
    endcase
  end

endmodule

// File: source/ctrlQueue.sv
// in-order control-transfer queue between fetch and commit.
// hands out tags, records resolutions, rolls back and emits predictor updates.
`timescale 1ns/1ps
`include "fetch_settings.svh"

module ctrlQueue import fetchIsaPkg::*, fetchPipePkg::*; (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             allocEn_i,
  input  slotMaskT                         allocMask_i,
  input  pcT       [`FETCH_BANDWIDTH-1:0]  allocPc_i,
  input  ctrlTypeE [`FETCH_BANDWIDTH-1:0]  allocType_i,
  output ctiqTagT  [`FETCH_BANDWIDTH-1:0]  allocTag_o,
  output logic                             full_o,
  input  logic                             recoverFlag_i,
  input  logic                             ctrlVerified_i,
  input  ctiqTagT                          ctiQueueIndex_i,
  input  logic                             branchOutcome_i,
  input  pcT                               resolvedTarget_i,
  input  logic                             mispredict_i,
  input  logic                             commitCti_i,
  output pcT                               updatePc_o,
  output pcT                               updateTarget_o,
  output ctrlTypeE                         updateCtrlType_o,
  output logic                             updateDir_o,
  output logic                             updateEn_o
);

  pcT       entryPc       [`CTIQ_DEPTH];
  ctrlTypeE entryType     [`CTIQ_DEPTH];
  logic     entryDir      [`CTIQ_DEPTH];
  pcT       entryTarget   [`CTIQ_DEPTH];
  logic     entryVerified [`CTIQ_DEPTH];

  ctiqTagT                headPtr;
  ctiqTagT                tailPtr;
  logic [`SIZE_CTI_LOG:0] count;

  ctiqTagT                headNext;
  ctiqTagT                tailNext;
  logic [`SIZE_CTI_LOG:0] countNext;
  logic [`SIZE_CTI_LOG:0] allocNum;
  logic [`SIZE_CTI_LOG:0] allocStep;
  logic [`SIZE_CTI_LOG:0] commitStep;
  logic                   rollback;
  logic                   allocWrite;

  // fewer free entries than one bundle can ask for.
  assign full_o = count > (`SIZE_CTI_LOG+1)'(`CTIQ_DEPTH - `FETCH_BANDWIDTH);

  // prefix count over the mask gives slot-ordered tags from the tail.
  always_comb begin
    allocNum = '0;
    for (int i = 0; i < `FETCH_BANDWIDTH; i++) begin
      allocTag_o[i] = allocMask_i[i] ? tailPtr + allocNum[`SIZE_CTI_LOG-1:0] : '0;
      allocNum      = allocNum + {`SIZE_CTI_LOG'(0), allocMask_i[i]};
    end
  end

  assign rollback   = ctrlVerified_i & mispredict_i;
  assign allocWrite = allocEn_i & ~recoverFlag_i & ~rollback; // wrong-path bundle is dropped.
  assign allocStep  = allocWrite ? allocNum : '0;
  assign commitStep = {`SIZE_CTI_LOG'(0), commitCti_i};

  always_comb begin
    headNext  = headPtr + ctiqTagT'(commitCti_i);
    tailNext  = tailPtr + allocStep[`SIZE_CTI_LOG-1:0];
    countNext = count + allocStep - commitStep;
    if (recoverFlag_i) begin
      tailNext  = headNext;
      countNext = '0;
    end else if (rollback) begin
      // keep head through the mispredicted entry.
      tailNext  = ctiQueueIndex_i + 1'b1;
      countNext = {1'b0, ctiqTagT'(ctiQueueIndex_i - headPtr)} + 1'b1 - commitStep;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      headPtr    <= '0;
      tailPtr    <= '0;
      count      <= '0;
      updateEn_o <= 1'b0;
    end else begin
      headPtr    <= headNext;
      tailPtr    <= tailNext;
      count      <= countNext;
      updateEn_o <= commitCti_i; // one cycle after the retire.
    end
  end

  always_ff @(posedge clk) begin
    if (ctrlVerified_i) begin
      entryVerified[ctiQueueIndex_i] <= 1'b1;
      entryDir[ctiQueueIndex_i]      <= branchOutcome_i;
      entryTarget[ctiQueueIndex_i]   <= resolvedTarget_i;
    end
    for (int i = 0; i < `FETCH_BANDWIDTH; i++) begin
      if (allocWrite && allocMask_i[i]) begin
        entryPc[allocTag_o[i]]       <= allocPc_i[i];
        entryType[allocTag_o[i]]     <= allocType_i[i];
        entryVerified[allocTag_o[i]] <= 1'b0;
      end
    end
    if (commitCti_i) begin
      updatePc_o       <= entryPc[headPtr];
      updateTarget_o   <= entryTarget[headPtr];
      updateCtrlType_o <= entryType[headPtr];
      updateDir_o      <= entryDir[headPtr];
    end
  end

endmodule

// File: source/fetchStage2.sv
// second fetch stage, pre-decodes a four slot bundle and checks it against the btb.
// sits between fetch stage 1 and decode, and owns the control-transfer queue.
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetchStage2 import fetchIsaPkg::*, fetchPipePkg::*; (
  input  logic                                        clk,
  input  logic                                        reset_i,
  input  logic                                        fs1Ready_i,
  input  pcT                                          pc_i,
  input  logic [`FETCH_BANDWIDTH*`SIZE_INSTRUCTION-1:0] instructionBundle_i,
  input  slotMaskT                                    btbHit_i,
  input  pcT       [`FETCH_BANDWIDTH-1:0]             btbTarget_i,
  input  slotMaskT                                    prediction_i,
  input  pcT                                          addrRas_i,
  input  logic                                        stall_i,
  input  logic                                        recoverFlag_i,
  input  logic                                        ctrlVerified_i,
  input  ctiqTagT                                     ctiQueueIndex_i,
  input  logic                                        branchOutcome_i,
  input  pcT                                          resolvedTarget_i,
  input  logic                                        mispredict_i,
  input  logic                                        commitCti_i,
  output slotMaskT                                    slotValid_o,
  output instrU    [`FETCH_BANDWIDTH-1:0]             slotInstr_o,
  output pcT       [`FETCH_BANDWIDTH-1:0]             slotPc_o,
  output pcT       [`FETCH_BANDWIDTH-1:0]             slotTarget_o,
  output ctiqTagT  [`FETCH_BANDWIDTH-1:0]             slotTag_o,
  output slotMaskT                                    slotPred_o,
  output logic                                        flagRecoverId_o,
  output pcT                                          targetAddrId_o,
  output logic                                        flagRtrId_o,
  output logic                                        flagCallId_o,
  output pcT                                          callPcId_o,
  output pcT                                          updatePc_o,
  output pcT                                          updateTarget_o,
  output ctrlTypeE                                    updateCtrlType_o,
  output logic                                        updateDir_o,
  output logic                                        updateEn_o,
  output logic                                        fs2Ready_o,
  output logic                                        ctiQueueFull_o
);

  instrU    [`FETCH_BANDWIDTH-1:0] slotInstr;
  pcT       [`FETCH_BANDWIDTH-1:0] slotPc;
  pcT       [`FETCH_BANDWIDTH-1:0] decTarget;
  ctrlTypeE [`FETCH_BANDWIDTH-1:0] ctrlType;
  slotMaskT                        isCtrl;
  slotMaskT                        takenVec;
  slotMaskT                        firstTaken;
  slotMaskT                        allocMask;

  logic     queueFull;
  logic     accept;
  logic     takenMiss;
  logic     redirectRtr;
  ctrlTypeE takenType;
  pcT       redirTarget;
  pcT       redirPc;

  assign slotInstr = instructionBundle_i; // slot 0 sits in the low word.

  for (genvar i = 0; i < `FETCH_BANDWIDTH; i++) begin : slotGen
    assign slotPc[i] = pc_i + pcT'(4 * i);

    preDecode slotDecode (
      .pc_i          (slotPc[i]),
      .instruction_i (slotInstr[i]),
      .btbTarget_i   (btbTarget_i[i]),
      .isCtrl_o      (isCtrl[i]),
      .ctrlType_o    (ctrlType[i]),
      .target_o      (decTarget[i])
    );

    // ras address replaces the btb guess for a missed return.
    assign slotTarget_o[i] = (firstTaken[i] & redirectRtr) ? addrRas_i : decTarget[i];
  end

  // taken if unconditional or predicted taken.
  always_comb begin
    for (int i = 0; i < `FETCH_BANDWIDTH; i++) begin
      takenVec[i] = isCtrl[i] & (prediction_i[i] | (ctrlType[i] != ctrlCondBranch));
    end
  end

  assign firstTaken  = takenVec & (~takenVec + 1'b1); // lowest set bit.
  assign slotValid_o = (takenVec == '0) ? '1 : (firstTaken | (firstTaken - 1'b1));

  always_comb begin
    redirTarget = '0;
    redirPc     = '0;
    takenMiss   = 1'b0;
    takenType   = ctrlJump;
    for (int i = 0; i < `FETCH_BANDWIDTH; i++) begin
      if (firstTaken[i]) begin
        redirTarget = decTarget[i];
        redirPc     = slotPc[i];
        takenMiss   = ~btbHit_i[i];
        takenType   = ctrlType[i];
      end
    end
  end

  assign redirectRtr     = takenMiss & (takenType == ctrlReturn);
  assign flagRtrId_o     = redirectRtr;
  assign flagCallId_o    = takenMiss & (takenType == ctrlCall); // stage 1 pushes callPcId_o.
  assign targetAddrId_o  = redirectRtr ? addrRas_i : redirTarget;
  assign callPcId_o      = redirPc;
  assign flagRecoverId_o = takenMiss & ~stall_i & ~queueFull;

  // every surviving control slot takes a tag, taken or not.
  assign allocMask = slotValid_o & isCtrl;
  assign accept    = fs1Ready_i & ~stall_i & ~queueFull;

  ctrlQueue ctiQueue (
    .clk              (clk),
    .reset_i          (reset_i),
    .allocEn_i        (accept),
    .allocMask_i      (allocMask),
    .allocPc_i        (slotPc),
    .allocType_i      (ctrlType),
    .allocTag_o       (slotTag_o),
    .full_o           (queueFull),
    .recoverFlag_i    (recoverFlag_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctiQueueIndex_i  (ctiQueueIndex_i),
    .branchOutcome_i  (branchOutcome_i),
    .resolvedTarget_i (resolvedTarget_i),
    .mispredict_i     (mispredict_i),
    .commitCti_i      (commitCti_i),
    .updatePc_o       (updatePc_o),
    .updateTarget_o   (updateTarget_o),
    .updateCtrlType_o (updateCtrlType_o),
    .updateDir_o      (updateDir_o),
    .updateEn_o       (updateEn_o)
  );

  assign slotInstr_o    = slotInstr;
  assign slotPc_o       = slotPc;
  assign slotPred_o     = prediction_i;
  assign ctiQueueFull_o = queueFull;
  assign fs2Ready_o     = fs1Ready_i & ~queueFull;

endmodule

// File: verif/ctrlQueue_chk.sv
// protocol assertions for the control-transfer queue, bound into ctrlQueue.
`timescale 1ns/1ps
`include "fetch_settings.svh"

module ctrlQueueChk (
  input logic                   clk,
  input logic                   reset_i,
  input logic                   commitCti_i,
  input logic                   headVerified_i,
  input logic                   updateEn_i,
  input logic [`SIZE_CTI_LOG:0] count_i
);

  commitNotEmpty: assert property (@(posedge clk) disable iff (reset_i)
    commitCti_i |-> count_i != '0)
    else $error("commit while the queue is empty");

  commitVerified: assert property (@(posedge clk) disable iff (reset_i)
    commitCti_i |-> headVerified_i)
    else $error("commit of an unverified head entry");

  // update strobe is the commit delayed by one cycle.
  updateFollows: assert property (@(posedge clk) disable iff (reset_i)
    1'b1 |=> updateEn_i == $past(commitCti_i))
    else $error("update enable does not follow commit");

  countBound: assert property (@(posedge clk) disable iff (reset_i)
    count_i <= (`SIZE_CTI_LOG+1)'(`CTIQ_DEPTH))
    else $error("queue count above depth");

endmodule

bind ctrlQueue ctrlQueueChk queueChk (
  .clk            (clk),
  .reset_i        (reset_i),
  .commitCti_i    (commitCti_i),
  .headVerified_i (entryVerified[headPtr]),
  .updateEn_i     (updateEn_o),
  .count_i        (count)
);

// File: verif/fetchStage2Tb.sv
// testbench for fetch stage 2 driving random bundles against a reference model.
// run through all.f; the queue model predicts tags and update records.
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetchStage2Tb import fetchIsaPkg::*, fetchPipePkg::*; ();

  localparam int plannedCycles = 560;
  localparam int nb = `FETCH_BANDWIDTH;

  logic clk = 1'b0;
  logic reset_i;
  logic fs1Ready, stall, recoverFlag, ctrlVerified, branchOutcome, mispredict, commitCti;
  logic [nb*32-1:0] bundle;
  pcT pc, addrRas, resolvedTarget;
  pcT [nb-1:0] btbTarget;
  slotMaskT btbHit, prediction;
  ctiqTagT ctiIndex;

  slotMaskT slotValid, slotPred;
  instrU [nb-1:0] slotInstr;
  pcT [nb-1:0] slotPc, slotTarget;
  ctiqTagT [nb-1:0] slotTag;
  logic flagRecover, flagRtr, flagCall, updateEn, updateDir, fs2Ready, queueFull;
  pcT targetAddr, callPc, updatePc, updateTarget;
  ctrlTypeE updateType;

  integer seed = 50;
  int errors = 0;
  int checks = 0;
  int tests = 0;

  // queue model state as it stands after the coming edge.
  pcT mPc [`CTIQ_DEPTH];
  ctrlTypeE mType [`CTIQ_DEPTH];
  logic mDir [`CTIQ_DEPTH];
  pcT mTarget [`CTIQ_DEPTH];
  logic mVer [`CTIQ_DEPTH];
  ctiqTagT mHead, mTail;
  int mCount;
  logic expUpdEn;
  pcT expUpdPc, expUpdTarget;
  ctrlTypeE expUpdType;
  logic expUpdDir;

  fetchStage2 uut (
    .clk(clk), .reset_i(reset_i), .fs1Ready_i(fs1Ready), .pc_i(pc),
    .instructionBundle_i(bundle), .btbHit_i(btbHit), .btbTarget_i(btbTarget),
    .prediction_i(prediction), .addrRas_i(addrRas), .stall_i(stall),
    .recoverFlag_i(recoverFlag), .ctrlVerified_i(ctrlVerified), .ctiQueueIndex_i(ctiIndex),
    .branchOutcome_i(branchOutcome), .resolvedTarget_i(resolvedTarget),
    .mispredict_i(mispredict), .commitCti_i(commitCti), .slotValid_o(slotValid),
    .slotInstr_o(slotInstr), .slotPc_o(slotPc), .slotTarget_o(slotTarget),
    .slotTag_o(slotTag), .slotPred_o(slotPred), .flagRecoverId_o(flagRecover),
    .targetAddrId_o(targetAddr), .flagRtrId_o(flagRtr), .flagCallId_o(flagCall),
    .callPcId_o(callPc), .updatePc_o(updatePc), .updateTarget_o(updateTarget),
    .updateCtrlType_o(updateType), .updateDir_o(updateDir), .updateEn_o(updateEn),
    .fs2Ready_o(fs2Ready), .ctiQueueFull_o(queueFull)
  );

  always #20 clk = ~clk;

  task automatic checkPc(input pcT got, input pcT exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkInstr(input instrU got, input instrU exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkTag(input ctiqTagT got, input ctiqTagT exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkMask(input slotMaskT got, input slotMaskT exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkType(input ctrlTypeE got, input ctrlTypeE exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // applies the target and validation rules to one bundle and returns the valid mask.
  function automatic slotMaskT expectBundle(
    input pcT basePc, input logic [nb*32-1:0] words, input slotMaskT hit,
    input pcT [nb-1:0] btbT, input slotMaskT pred, input pcT ras,
    output pcT [nb-1:0] target, output slotMaskT ctrl, output ctrlTypeE [nb-1:0] kind,
    output logic miss, output pcT redirTgt, output logic rtr, output logic call,
    output pcT missPc);
    logic [31:0] w;
    pcT spc;
    slotMaskT valid;
    logic found;
    valid = '1;
    found = 1'b0;
    miss = 1'b0;
    rtr = 1'b0;
    call = 1'b0;
    redirTgt = '0;
    missPc = '0;
    for (int i = 0; i < nb; i++) begin
      w = words[32*i +: 32];
      spc = basePc + pcT'(4 * i);
      ctrl[i] = 1'b1;
      kind[i] = ctrlJump;
      target[i] = spc + 4;
      case (w[31:26])
        opJr: begin
          kind[i] = ctrlReturn;
          target[i] = btbT[i];
        end
        opJal: begin
          kind[i] = ctrlCall;
          target[i] = {spc[31:28], w[25:0], 2'b00};
        end
        opJ: target[i] = {spc[31:28], w[25:0], 2'b00};
        opBeq, opBne: begin
          kind[i] = ctrlCondBranch;
          target[i] = spc + 4 + ({{16{w[15]}}, w[15:0]} << 2);
        end
        default: ctrl[i] = 1'b0;
      endcase
      if (!found && ctrl[i] && (pred[i] || kind[i] != ctrlCondBranch)) begin
        found = 1'b1;
        valid = slotMaskT'((1 << (i + 1)) - 1);
        miss = !hit[i];
        missPc = spc;
        redirTgt = target[i];
        if (miss && kind[i] == ctrlReturn) begin
          rtr = 1'b1;
          target[i] = ras;
          redirTgt = ras;
        end
        call = miss && kind[i] == ctrlCall;
      end
    end
    return valid;
  endfunction

  // checks at the falling edge and then steps the model.
  always @(negedge clk) begin : compare
    pcT [nb-1:0] expTarget;
    slotMaskT ctrl, expValid, mask;
    ctrlTypeE [nb-1:0] kind;
    logic miss, rtr, call, full, accept, rollback, allocWrite;
    pcT redirTgt, missPc;
    ctiqTagT [nb-1:0] expTag;
    int n;
    if (reset_i) begin
      mHead = '0;
      mTail = '0;
      mCount = 0;
      expUpdEn = 1'b0;
      for (int j = 0; j < `CTIQ_DEPTH; j++) begin
        mVer[j] = 1'b0;
      end
    end else begin
      expValid = expectBundle(pc, bundle, btbHit, btbTarget, prediction, addrRas,
                              expTarget, ctrl, kind, miss, redirTgt, rtr, call, missPc);
      full = mCount > `CTIQ_DEPTH - nb;
      mask = expValid & ctrl;
      n = 0;
      for (int i = 0; i < nb; i++) begin
        expTag[i] = mask[i] ? ctiqTagT'(mTail + n) : '0;
        if (mask[i]) n++;
        checkInstr(slotInstr[i], bundle[32*i +: 32], $sformatf("slot %0d instruction", i));
        checkPc(slotPc[i], pc + pcT'(4 * i), $sformatf("slot %0d pc", i));
        checkPc(slotTarget[i], expTarget[i], $sformatf("slot %0d target", i));
        checkTag(slotTag[i], expTag[i], $sformatf("slot %0d tag", i));
      end
      checkMask(slotValid, expValid, "slot valid");
      checkMask(slotPred, prediction, "slot prediction");
      checkBit(flagRecover, miss & ~stall & ~full, "redirect flag");
      checkBit(flagRtr, rtr, "return flag");
      checkBit(flagCall, call, "call flag");
      if (miss) begin
        checkPc(targetAddr, redirTgt, "redirect target");
        checkPc(callPc, missPc, "redirect pc");
      end
      checkBit(queueFull, full, "queue full");
      checkBit(fs2Ready, fs1Ready & ~full, "stage ready");
      checkBit(updateEn, expUpdEn, "update enable");
      if (expUpdEn) begin
        checkPc(updatePc, expUpdPc, "update pc");
        checkPc(updateTarget, expUpdTarget, "update target");
        checkType(updateType, expUpdType, "update type");
        checkBit(updateDir, expUpdDir, "update direction");
      end
      // effect of the coming edge.
      expUpdEn = commitCti;
      if (commitCti) begin
        expUpdPc = mPc[mHead];
        expUpdTarget = mTarget[mHead];
        expUpdType = mType[mHead];
        expUpdDir = mDir[mHead];
      end
      accept = fs1Ready & ~stall & ~full;
      rollback = ctrlVerified & mispredict;
      allocWrite = accept & ~recoverFlag & ~rollback;
      if (ctrlVerified) begin
        mVer[ctiIndex] = 1'b1;
        mDir[ctiIndex] = branchOutcome;
        mTarget[ctiIndex] = resolvedTarget;
      end
      if (allocWrite) begin
        for (int i = 0; i < nb; i++) begin
          if (mask[i]) begin
            mPc[expTag[i]] = pc + pcT'(4 * i);
            mType[expTag[i]] = kind[i];
            mVer[expTag[i]] = 1'b0;
          end
        end
      end
      if (recoverFlag) begin
        mHead = mHead + ctiqTagT'(commitCti);
        mTail = mHead;
        mCount = 0;
      end else if (rollback) begin
        mCount = int'(ctiqTagT'(ctiIndex - mHead)) + 1 - int'(commitCti);
        mHead = mHead + ctiqTagT'(commitCti);
        mTail = ctiIndex + 1'b1;
      end else begin
        mHead = mHead + ctiqTagT'(commitCti);
        mTail = mTail + ctiqTagT'(allocWrite ? n : 0);
        mCount = mCount + (allocWrite ? n : 0) - int'(commitCti);
      end
    end
  end

  function automatic logic [5:0] pickOpcode(input logic allowCtrl);
    logic [5:0] ops [12];
    int k;
    ops = '{6'h00, 6'h00, 6'h20, 6'h23, 6'h2b, 6'h0d,
            opBeq, opBne, opJ, opJal, opJr, opBeq};
    k = allowCtrl ? ($unsigned($random(seed)) % 12) : ($unsigned($random(seed)) % 6);
    return ops[k];
  endfunction

  // drives one cycle of stimulus while the model already shows the state after this edge.
  task automatic driveCycle(input logic allowCtrl, input logic fetchOn, input logic recoverOn);
    @(posedge clk);
    for (int i = 0; i < nb; i++) begin
      bundle[32*i +: 32] <= {pickOpcode(allowCtrl), 26'($random(seed))};
      btbTarget[i] <= pcT'($random(seed));
    end
    pc <= {$random(seed)} & 32'hffff_fff0;
    fs1Ready <= fetchOn & ($random(seed) % 8 != 0);
    stall <= ($random(seed) % 6 == 0);
    btbHit <= slotMaskT'($random(seed));
    prediction <= slotMaskT'($random(seed));
    addrRas <= pcT'($random(seed));
    resolvedTarget <= pcT'($random(seed));
    branchOutcome <= 1'($random(seed));
    ctiIndex <= mHead;
    ctrlVerified <= mCount > 0 && !mVer[mHead] && $random(seed) % 2 == 0;
    mispredict <= ($random(seed) % 8 == 0);
    commitCti <= mCount > 0 && mVer[mHead] && $random(seed) % 2 == 0;
    recoverFlag <= recoverOn && ($random(seed) % 40 == 0);
  endtask

  task automatic finishTest(input string name, input int errBefore);
    tests++;
    $display("test %s finished with %0d errors", name, errors - errBefore);
  endtask

  initial begin : watchdog
    #(plannedCycles * 40 * 2);
    $display("run timed out before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    int errBefore;
    int waitCycles;
    reset_i = 1'b1;
    fs1Ready = 1'b0;
    stall = 1'b0;
    recoverFlag = 1'b0;
    ctrlVerified = 1'b0;
    branchOutcome = 1'b0;
    mispredict = 1'b0;
    commitCti = 1'b0;
    bundle = '0;
    pc = '0;
    addrRas = '0;
    resolvedTarget = '0;
    btbTarget = '0;
    btbHit = '0;
    prediction = '0;
    ctiIndex = '0;
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;

    errBefore = errors;
    repeat (12) driveCycle(1'b0, 1'b1, 1'b0);
    finishTest("sequential bundles", errBefore);

    errBefore = errors;
    repeat (400) driveCycle(1'b1, 1'b1, 1'b1);
    finishTest("random control bundles", errBefore);

    // drain with fetch off and then recover and refill from the head.
    errBefore = errors;
    waitCycles = 0;
    while (mCount != 0 && waitCycles < 80) begin
      driveCycle(1'b1, 1'b0, 1'b0);
      waitCycles++;
    end
    if (mCount != 0) begin
      errors++;
      $display("queue did not drain within %0d cycles", waitCycles);
    end
    repeat (4) driveCycle(1'b1, 1'b1, 1'b0);
    @(posedge clk);
    recoverFlag <= 1'b1;
    ctrlVerified <= 1'b0;
    commitCti <= 1'b0;
    repeat (20) driveCycle(1'b1, 1'b1, 1'b0);
    finishTest("drain and recovery", errBefore);

    // let the last falling-edge compare finish first.
    @(negedge clk);
    #1;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+source
source/fetchIsaPkg.sv
source/fetchPipePkg.sv
source/preDecode.sv
source/ctrlQueue.sv
source/fetchStage2.sv
verif/ctrlQueue_chk.sv
verif/fetchStage2Tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch stage 2 testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f all.f \
  --top-module fetchStage2Tb \
  -o simFetchStage2

out=$(./obj_dir/simFetchStage2)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
